//--- compute_tile_bus.f
design/ct_pkg.sv
design/wb_onehot_mux.sv
design/wb_burst_addr.sv
design/wb_bus_ctrl.sv
design/wb_sram.sv
design/wb_bootrom.sv
design/compute_tile_bus.sv
dv/tb_compute_tile.sv

//--- design/compute_tile_bus.sv
`default_nettype none

module compute_tile_bus #(
   parameter int MASTERS   = 2,
   parameter int MEM_WORDS = 1024
) (
   input  wire                                 clk,
   input  wire                                 reset_i,
   input  wire  [MASTERS-1:0]                  m_cyc_i,
   input  wire  [MASTERS-1:0]                  m_stb_i,
   input  wire  [MASTERS-1:0]                  m_we_i,
   input  wire  [MASTERS-1:0][ct_pkg::AW-1:0]  m_adr_i,
   input  wire  [MASTERS-1:0][ct_pkg::DW-1:0]  m_dat_i,
   input  wire  [MASTERS-1:0][ct_pkg::SW-1:0]  m_sel_i,
   input  wire  [MASTERS-1:0][2:0]             m_cti_i,
   input  wire  [MASTERS-1:0][1:0]             m_bte_i,
   output logic [MASTERS-1:0]                  m_ack_o,
   output logic [MASTERS-1:0]                  m_err_o,
   output logic [ct_pkg::DW-1:0]               m_dat_o
);

   ct_pkg::wb_req_t [MASTERS-1:0]                       m_req;
   ct_pkg::wb_req_t                                     s_req;
   logic [MASTERS-1:0]                                  grant;
   logic [ct_pkg::NR_SLAVES-1:0]                        slave_sel;
   logic [ct_pkg::NR_SLAVES-1:0]                        s_ack;
   logic [ct_pkg::NR_SLAVES-1:0][ct_pkg::DW-1:0]        s_dat;

   for (genvar m = 0; m < MASTERS; m++) begin : gen_req
      assign m_req[m] = '{
         adr: m_adr_i[m],
         dat: m_dat_i[m],
         sel: m_sel_i[m],
         we:  m_we_i[m],
         cti: m_cti_i[m],
         bte: m_bte_i[m],
         stb: m_stb_i[m]
      };
   end

   wb_bus_ctrl #(
      .MASTERS (MASTERS)
   ) u_bus_ctrl (
      .clk         (clk),
      .reset_i     (reset_i),
      .m_cyc_i     (m_cyc_i),
      .adr_i       (s_req.adr),
      .s_ack_i     (|s_ack),                              // At most one slave selected
      .grant_o     (grant),
      .slave_sel_o (slave_sel),
      .m_ack_o     (m_ack_o),
      .m_err_o     (m_err_o)
   );

   // Granted master's request goes to both slaves
   wb_onehot_mux #(
      .N         (MASTERS),
      .payload_t (ct_pkg::wb_req_t)
   ) u_req_mux (
      .sel_i (grant),
      .in_i  (m_req),
      .out_o (s_req)
   );

   wb_onehot_mux #(
      .N         (ct_pkg::NR_SLAVES),
      .payload_t (logic [ct_pkg::DW-1:0])
   ) u_rdata_mux (
      .sel_i (slave_sel),
      .in_i  (s_dat),
      .out_o (m_dat_o)
   );

   wb_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_sram (
      .clk     (clk),
      .reset_i (reset_i),
      .sel_i   (slave_sel[0]),
      .req_i   (s_req),
      .ack_o   (s_ack[0]),
      .dat_o   (s_dat[0])
   );

   wb_bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .sel_i   (slave_sel[1]),
      .req_i   (s_req),
      .ack_o   (s_ack[1]),
      .dat_o   (s_dat[1])
   );

endmodule

`default_nettype wire

//--- design/ct_pkg.sv
`default_nettype none

package ct_pkg;

   localparam int DW = 32;                 // Data bus width
   localparam int AW = 32;                 // Byte address width
   localparam int SW = DW / 8;             // Byte lane selects

   // Wishbone B3 cycle type identifiers
   localparam logic [2:0] CTI_CLASSIC = 3'b000;
   localparam logic [2:0] CTI_INCR    = 3'b010;
   localparam logic [2:0] CTI_END     = 3'b111;

   localparam logic [1:0] BTE_LINEAR = 2'b00;
   localparam logic [1:0] BTE_WRAP4  = 2'b01;
   localparam logic [1:0] BTE_WRAP8  = 2'b10;
   localparam logic [1:0] BTE_WRAP16 = 2'b11;

   localparam logic       SRAM_MATCH = 1'b0;  // On adr[31]
   localparam logic [3:0] NA_MATCH   = 4'he;  // On adr[31:28], no slave behind it
   localparam logic [3:0] ROM_MATCH  = 4'hf;  // On adr[31:28]

   localparam int NR_SLAVES = 2;           // SRAM is 0, boot ROM is 1

   // One master's request as seen by the slaves
   typedef struct packed {
      logic [AW-1:0] adr;
      logic [DW-1:0] dat;
      logic [SW-1:0] sel;
      logic          we;
      logic [2:0]    cti;
      logic [1:0]    bte;
      logic          stb;
   } wb_req_t;

   localparam int ROM_WORDS = 8;

   // Sets up r1 as stack pointer and jumps into SRAM
   localparam logic [0:ROM_WORDS-1][DW-1:0] ROM_TABLE = '{
      32'h1800_0000, 32'h1820_0000, 32'ha821_1000, 32'h1860_0000,
      32'ha863_0100, 32'h4400_1800, 32'h1500_0000, 32'h1500_0001
   };

endpackage

`default_nettype wire

//--- design/wb_bootrom.sv
`default_nettype none

module wb_bootrom (
   input  wire                   clk,
   input  wire                   reset_i,
   input  wire                   sel_i,
   input  wire  ct_pkg::wb_req_t req_i,
   output logic                  ack_o,
   output logic [ct_pkg::DW-1:0] dat_o
);

   localparam int XW = $clog2(ct_pkg::ROM_WORDS);

   logic          accept;
   logic [XW-1:0] idx;

   assign accept = sel_i && req_i.stb && !ack_o;          // Classic beats only
   assign idx    = req_i.adr[XW+1:2];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= accept;                                 // One-cycle pulse, writes too
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dat_o <= ct_pkg::ROM_TABLE[idx];
      end
   end

endmodule

`default_nettype wire

//--- design/wb_burst_addr.sv
`default_nettype none

module wb_burst_addr (
   input  wire                   clk,
   input  wire                   reset_i,
   input  wire                   start_i,     // First beat accepted
   input  wire                   advance_i,   // Further beat accepted
   input  wire  [ct_pkg::AW-1:0] adr_i,
   input  wire  [1:0]            bte_i,
   output logic [ct_pkg::AW-1:0] adr_o        // Byte address of the next beat's word
);

   localparam int AW = ct_pkg::AW;

   logic [AW-1:0] adr_q;
   logic [AW-1:0] cur;
   logic [AW-1:0] inc;
   logic [AW-1:0] nxt;

   assign cur = start_i ? {adr_i[AW-1:2], 2'b00} : adr_q;
   assign inc = cur + AW'(4);

   // Wrap bursts keep everything above the window fixed
   always_comb begin
      case (bte_i)
         ct_pkg::BTE_WRAP4:  nxt = {cur[AW-1:4], inc[3:2], 2'b00};
         ct_pkg::BTE_WRAP8:  nxt = {cur[AW-1:5], inc[4:2], 2'b00};
         ct_pkg::BTE_WRAP16: nxt = {cur[AW-1:6], inc[5:2], 2'b00};
         default:            nxt = inc;                   // Linear increment
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         adr_q <= '0;
      end else if (start_i || advance_i) begin
         adr_q <= nxt;
      end
   end

   assign adr_o = adr_q;

endmodule

`default_nettype wire

//--- design/wb_bus_ctrl.sv
`default_nettype none

module wb_bus_ctrl #(
   parameter int MASTERS = 2
) (
   input  wire                             clk,
   input  wire                             reset_i,
   input  wire  [MASTERS-1:0]              m_cyc_i,
   input  wire  [ct_pkg::AW-1:0]           adr_i,       // Address of the granted request
   input  wire                             s_ack_i,
   output logic [MASTERS-1:0]              grant_o,
   output logic [ct_pkg::NR_SLAVES-1:0]    slave_sel_o,
   output logic [MASTERS-1:0]              m_ack_o,
   output logic [MASTERS-1:0]              m_err_o
);

   localparam int IW = (MASTERS > 1) ? $clog2(MASTERS) : 1;

   typedef enum logic [1:0] {IDLE, BUSY, ERR} state_t;

   state_t                        state_q;
   logic [MASTERS-1:0]            grant_q;
   logic [MASTERS-1:0]            next_grant;
   logic [IW-1:0]                 last_q;
   logic [IW-1:0]                 next_idx;
   logic [ct_pkg::NR_SLAVES-1:0]  sel_q;
   logic [ct_pkg::NR_SLAVES-1:0]  dec;
   logic                          err_arm_q;
   logic                          err_q;

   // Round-robin pick, starting after the last granted master
   always_comb begin : rr_pick
      int idx;
      next_grant = '0;
      next_idx   = last_q;
      for (int i = 1; i <= MASTERS; i++) begin
         idx = (int'(last_q) + i) % MASTERS;
         if (m_cyc_i[idx] && next_grant == '0) begin
            next_grant[idx] = 1'b1;
            next_idx        = IW'(idx);
         end
      end
   end

   always_comb begin
      dec = '0;
      if (adr_i[ct_pkg::AW-1] == ct_pkg::SRAM_MATCH) begin
         dec[0] = 1'b1;                                   // Local SRAM
      end else if (adr_i[ct_pkg::AW-1 -: 4] == ct_pkg::ROM_MATCH) begin
         dec[1] = 1'b1;                                   // Boot ROM
      end else if (adr_i[ct_pkg::AW-1 -: 4] == ct_pkg::NA_MATCH) begin
         dec = '0;                                        // Former network adapter
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q   <= IDLE;
         grant_q   <= '0;
         last_q    <= '0;
         sel_q     <= '0;
         err_arm_q <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         err_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (|m_cyc_i) begin
                  grant_q   <= next_grant;
                  last_q    <= next_idx;
                  sel_q     <= dec;                       // Decode registered at grant
                  err_arm_q <= (dec == '0);
                  state_q   <= (dec == '0) ? ERR : BUSY;
               end
            end
            BUSY: begin
               if ((m_cyc_i & grant_q) == '0) begin
                  state_q <= IDLE;
                  grant_q <= '0;
                  sel_q   <= '0;
               end
            end
            default: begin                                // ERR, one err pulse then wait
               err_q     <= err_arm_q;
               err_arm_q <= 1'b0;
               if ((m_cyc_i & grant_q) == '0) begin
                  state_q <= IDLE;
                  grant_q <= '0;
               end
            end
         endcase
      end
   end

   // Look-ahead grant in IDLE lets the decode see the winner's address
   assign grant_o     = (state_q == IDLE) ? next_grant : grant_q;
   assign slave_sel_o = sel_q;
   assign m_ack_o     = grant_q & {MASTERS{s_ack_i}};
   assign m_err_o     = grant_q & {MASTERS{err_q}};

   a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
      $onehot0(grant_o));

   // Slave ack and bus err never overlap for the granted master
   a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !((|m_ack_o) && (|m_err_o)));

endmodule

`default_nettype wire

//--- design/wb_onehot_mux.sv
`default_nettype none

module wb_onehot_mux #(
   parameter int  N         = 2,
   parameter type payload_t = logic [31:0]
) (
   input  wire  [N-1:0]           sel_i,
   input  wire  payload_t [N-1:0] in_i,
   output payload_t               out_o
);

   localparam int PW = $bits(payload_t);

   logic [PW-1:0] acc;

   // And-or tree, the select is one-hot so no priority is needed
   always_comb begin
      acc = '0;
      for (int i = 0; i < N; i++) begin
         acc = acc | (in_i[i] & {PW{sel_i[i]}});
      end
   end

   assign out_o = payload_t'(acc);

   always_comb begin
      a_sel_onehot: assert ($onehot0(sel_i));
   end

endmodule

`default_nettype wire

//--- design/wb_sram.sv
`default_nettype none

module wb_sram #(
   parameter int MEM_WORDS = 1024
) (
   input  wire                   clk,
   input  wire                   reset_i,
   input  wire                   sel_i,
   input  wire  ct_pkg::wb_req_t req_i,
   output logic                  ack_o,
   output logic [ct_pkg::DW-1:0] dat_o
);

   localparam int IW = $clog2(MEM_WORDS);

   logic [ct_pkg::DW-1:0] mem [MEM_WORDS];
   logic                  active;
   logic                  first;
   logic                  burst_more;
   logic [ct_pkg::AW-1:0] next_adr;
   logic [IW-1:0]         wr_idx;
   logic [IW-1:0]         rd_idx;

   assign active     = sel_i && req_i.stb;
   assign first      = active && !ack_o;                  // New cycle or resumed burst
   assign burst_more = active && ack_o && (req_i.cti == ct_pkg::CTI_INCR);

   assign wr_idx = req_i.adr[IW+1:2];
   assign rd_idx = first ? wr_idx : next_adr[IW+1:2];     // Later beats are prefetched

   wb_burst_addr u_burst_addr (
      .clk       (clk),
      .reset_i   (reset_i),
      .start_i   (first),
      .advance_i (burst_more),
      .adr_i     (req_i.adr),
      .bte_i     (req_i.bte),
      .adr_o     (next_adr)
   );

   // Ack stays up across an incrementing burst, drops after the end beat
   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= first || burst_more;
      end
   end

   always_ff @(posedge clk) begin
      if (first || burst_more) begin
         dat_o <= mem[rd_idx];
      end
      if (active && req_i.we) begin                       // Bus holds adr and dat stable
         for (int b = 0; b < ct_pkg::SW; b++) begin
            if (req_i.sel[b]) begin
               mem[wr_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   // Ack only while the bus control still selects us and the master strobes
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset_i)
      ack_o |-> active);

endmodule

`default_nettype wire

//--- dv/tb_compute_tile.sv
`default_nettype none

module tb_compute_tile;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MASTERS    = 2;
   localparam int MEM_WORDS  = 1024;
   localparam int IW         = $clog2(MEM_WORDS);
   localparam int CLK_HALF   = 2;                        // 4 ns period
   localparam int N_TESTS    = 5;
   localparam int RESP_LIMIT = 64;                       // Cycles a master waits for ack or err
   localparam int WDOG_CYC   = 200 * N_TESTS + 1000;

   typedef struct {
      bit          err;
      bit          chk;                                  // Read data is compared
      logic [31:0] dat;
      longint      at;                                   // Cycle count when the response is sampled
   } exp_t;

   logic                        clk;
   logic                        reset;
   logic [MASTERS-1:0]          m_cyc;
   logic [MASTERS-1:0]          m_stb;
   logic [MASTERS-1:0]          m_we;
   logic [MASTERS-1:0][31:0]    m_adr;
   logic [MASTERS-1:0][31:0]    m_dat;
   logic [MASTERS-1:0][3:0]     m_sel;
   logic [MASTERS-1:0][2:0]     m_cti;
   logic [MASTERS-1:0][1:0]     m_bte;
   logic [MASTERS-1:0]          m_ack;
   logic [MASTERS-1:0]          m_err;
   logic [31:0]                 rd_dat;

   exp_t        exp_q [MASTERS][$];                      // Pending responses per master
   logic [31:0] shadow [MEM_WORDS];
   bit   [31:0] rng;
   longint      cyc_cnt;
   int          errs;                                    // Found by the stimulus side
   int          chk_errs;                                // Found by the compare process
   int          err_base;
   int          tests;
   int          fails;
   string       test_name;

   compute_tile_bus #(
      .MASTERS   (MASTERS),
      .MEM_WORDS (MEM_WORDS)
   ) DUT (
      .clk     (clk),
      .reset_i (reset),
      .m_cyc_i (m_cyc),
      .m_stb_i (m_stb),
      .m_we_i  (m_we),
      .m_adr_i (m_adr),
      .m_dat_i (m_dat),
      .m_sel_i (m_sel),
      .m_cti_i (m_cti),
      .m_bte_i (m_bte),
      .m_ack_o (m_ack),
      .m_err_o (m_err),
      .m_dat_o (rd_dat)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Address of the following beat, wrap bursts stay inside their window
   function automatic logic [31:0] next_adr(input logic [31:0] a, input logic [1:0] bte);
      logic [31:0] mask;
      case (bte)
         ct_pkg::BTE_WRAP4:  mask = 32'h0000_000f;
         ct_pkg::BTE_WRAP8:  mask = 32'h0000_001f;
         ct_pkg::BTE_WRAP16: mask = 32'h0000_003f;
         default:            mask = 32'hffff_ffff;
      endcase
      return (a & ~mask) | ((a + 32'd4) & mask);
   endfunction

   // Reference model of one beat: decode, byte-merged shadow SRAM, boot ROM
   function automatic exp_t model_access(input logic [31:0] adr, input logic [31:0] dat,
                                         input logic [3:0] sel, input bit we, input longint at);
      exp_t e;
      e.at  = at;
      e.err = 1'b0;
      e.chk = !we;
      e.dat = 'x;
      if (adr[31] == 1'b0) begin
         for (int b = 0; b < 4; b++) begin
            if (we && sel[b]) shadow[adr[IW+1:2]][8*b +: 8] = dat[8*b +: 8];
         end
         e.dat = shadow[adr[IW+1:2]];
      end else if (adr[31:28] == 4'hf) begin
         e.dat = ct_pkg::ROM_TABLE[adr[4:2]];
      end else begin
         e.err = 1'b1;                                   // Former adapter range or unmapped
         e.chk = 1'b0;
      end
      return e;
   endfunction

   // One classic cycle (n == 1) or an n-beat incrementing burst from master m
   task automatic bus_cycle(input int m, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input bit we, input logic [1:0] bte,
                            input int n, input int extra);
      logic [31:0] a;
      longint      start;
      int          t;
      @(posedge clk);
      start = cyc_cnt;
      a     = adr;
      for (int k = 0; k < n; k++) begin
         exp_q[m].push_back(model_access(a, dat, sel, we, start + 3 + extra + k));
         a = next_adr(a, bte);
      end
      m_cyc[m] <= 1'b1;
      m_stb[m] <= 1'b1;
      m_we[m]  <= we;
      m_adr[m] <= adr;
      m_dat[m] <= dat;
      m_sel[m] <= sel;
      m_bte[m] <= bte;
      m_cti[m] <= (n > 1) ? ct_pkg::CTI_INCR : ct_pkg::CTI_CLASSIC;
      a = adr;
      for (int k = 0; k < n; k++) begin
         t = 0;
         do begin
            @(negedge clk);
            t++;
         end while (!(m_ack[m] || m_err[m]) && t < RESP_LIMIT);
         assert (t < RESP_LIMIT) else begin
            $display("%s: master %0d got neither ack nor err in time", test_name, m);
            errs++;
         end
         @(posedge clk);
         a = next_adr(a, bte);
         m_adr[m] <= a;
         m_cti[m] <= (k + 2 == n) ? ct_pkg::CTI_END : ct_pkg::CTI_INCR;
      end
      m_cyc[m] <= 1'b0;
      m_stb[m] <= 1'b0;
   endtask

   task automatic end_test();
      int n;
      for (int m = 0; m < MASTERS; m++) begin
         assert (exp_q[m].size() == 0) else begin
            $display("%s: master %0d still waits for %0d responses", test_name, m,
                     exp_q[m].size());
            errs++;
         end
         exp_q[m].delete();
      end
      n        = errs + chk_errs - err_base;
      err_base = errs + chk_errs;
      tests++;
      if (n == 0) begin
         $display("%-10s ok", test_name);
      end else begin
         $display("%-10s %0d errors", test_name, n);
         fails++;
      end
   endtask

   always @(negedge clk) begin : compare
      exp_t e;
      if (!reset) begin
         for (int m = 0; m < MASTERS; m++) begin
            if (m_ack[m] || m_err[m]) begin
               assert (exp_q[m].size() != 0) else begin
                  $display("%s: master %0d got a response it never asked for", test_name, m);
                  chk_errs++;
               end
               if (exp_q[m].size() != 0) begin
                  e = exp_q[m].pop_front();
                  assert (m_err[m] == e.err && m_ack[m] != e.err) else begin
                     $display("Fail %s: master %0d expected %s, actual ack %b err %b",
                              test_name, m, e.err ? "err" : "ack", m_ack[m], m_err[m]);
                     chk_errs++;
                  end
                  assert (!e.chk || rd_dat === e.dat) else begin
                     $display("Fail %s: master %0d data expected %h, actual %h",
                              test_name, m, e.dat, rd_dat);
                     chk_errs++;
                  end
                  assert (cyc_cnt == e.at) else begin
                     $display("Fail %s: master %0d response cycle expected %0d, actual %0d",
                              test_name, m, e.at, cyc_cnt);
                     chk_errs++;
                  end
               end
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] a0;
      logic [31:0] d0;
      logic [31:0] d1;
      logic [3:0]  top;
      int          w;
      int          words [8];
      int          winner;
      int          rr_last;
      int          solo;
      bit          we;
      rng = 32'hd0904df9;
      m_cyc <= '0;
      m_stb <= '0;
      m_we  <= '0;
      m_adr <= '0;
      m_dat <= '0;
      m_sel <= '0;
      m_cti <= '0;
      m_bte <= '0;
      reset <= 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      test_name = "classic";
      for (int i = 0; i < 32; i++) bus_cycle(0, i * 4, xorshift32(), 4'hf, 1'b1, 2'b00, 1, 0);
      for (int i = 0; i < 16; i++) begin
         r = xorshift32();
         bus_cycle(0, {25'b0, r[4:0], 2'b00}, xorshift32(), r[11:8], 1'b1, 2'b00, 1, 0);
      end
      for (int i = 0; i < 32; i++) bus_cycle(0, i * 4, '0, 4'hf, 1'b0, 2'b00, 1, 0);
      end_test();

      test_name = "burst";
      for (int li = 0; li < 3; li++) begin
         for (int b = 0; b < 4; b++) begin
            r = xorshift32();
            w = int'(r % 12) | 1;                        // Odd word, never window aligned
            bus_cycle(0, w * 4, '0, 4'hf, 1'b0, 2'(b), 4 << li, 0);
         end
      end
      end_test();

      test_name = "bootrom";
      for (int i = 0; i < 8; i++) begin
         r = xorshift32();
         bus_cycle(0, {4'hf, r[27:2], 2'b00}, '0, 4'hf, 1'b0, 2'b00, 1, 0);
      end
      end_test();

      test_name = "unmapped";
      for (int i = 0; i < 8; i++) begin
         r        = xorshift32();
         words[i] = int'(r % 32);
         top      = (i % 2 == 0) ? 4'he : 4'(8 + int'(r[10:8]) % 6);
         bus_cycle(0, {top, 21'b0, 5'(words[i]), 2'b00}, xorshift32(), 4'hf, 1'b1, 2'b00, 1, 0);
      end
      for (int i = 0; i < 8; i++) bus_cycle(0, words[i] * 4, '0, 4'hf, 1'b0, 2'b00, 1, 0);
      end_test();

      test_name = "arbiter";
      rr_last = 0;                                       // Only master 0 was granted so far
      for (int ri = 0; ri < 6; ri++) begin
         we = (ri % 2 == 0);                             // Write a pair, then read it back
         a0 = (20 + ri / 2) * 4;
         d0 = xorshift32();
         d1 = xorshift32();
         if (!we) begin
            // Lone read by the last winner turns the round-robin pointer to it
            solo = 1 - rr_last;
            bus_cycle(solo, a0 + 32'(16 * solo), '0, 4'hf, 1'b0, 2'b00, 1, 0);
            rr_last = solo;
         end
         winner = (rr_last + 1) % MASTERS;
         fork
            bus_cycle(0, a0, d0, 4'hf, we, 2'b00, 1, (winner == 0) ? 0 : 4);
            bus_cycle(1, a0 + 32'd16, d1, 4'hf, we, 2'b00, 1, (winner == 1) ? 0 : 4);
         join
         rr_last = 1 - winner;                           // Loser was granted last
      end
      end_test();

      $display("%0d tests, %0d failed, %0d errors", tests, fails, errs + chk_errs);
      if (fails == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(WDOG_CYC * 2 * CLK_HALF);
      $display("Watchdog expired in %s, the bus stopped answering", test_name);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_compute_tile \
   -f compute_tile_bus.f

./obj_dir/Vtb_compute_tile | tee sim.log

if grep -q "^test failed$" sim.log; then
   exit 1
fi
exit 0
